//--- rtl/mem_arb_pkg.sv
`default_nettype none

package mem_arb_pkg;

    // shared memory geometry.
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // number of request ports.
    localparam int REQ_NB = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // level 3 is the highest.
    typedef logic [1:0] prio_t;

    // one bit per port.
    typedef logic [REQ_NB-1:0] req_vec_t;

endpackage

`default_nettype wire

//--- rtl/rr_core.sv
`timescale 1ns/10ps
`default_nettype none

module rr_core import mem_arb_pkg::*; (
    input  wire      aclk,
    input  wire      reset,
    input  wire      en,
    input  wire      req_vec_t req,
    output req_vec_t grant
);

    // positions at and after the pointer.
    req_vec_t mask;
    req_vec_t masked_req;
    req_vec_t pick_src;

    assign masked_req = req & mask;

    // wrap to the bottom when nothing sits above the pointer.
    assign pick_src = (|masked_req) ? masked_req : req;

    // lowest set bit only.
    assign grant = pick_src & (~pick_src + req_vec_t'(1));

    always_ff @(posedge aclk) begin
        if (reset) begin
            mask <= '1;
        end else if (en) begin
            // keep only the positions above the winner.
            mask <= ~((grant << 1) - req_vec_t'(1));
        end
    end

    // a granted request never belongs to an idle port.
    assert property (@(posedge aclk) disable iff (reset)
        $onehot0(grant) && ((grant & ~req) == '0));

endmodule

`default_nettype wire

//--- rtl/prio_rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module prio_rr_arbiter import mem_arb_pkg::*; #(
    parameter prio_t REQ0_PRIORITY = 2'd0,
    parameter prio_t REQ1_PRIORITY = 2'd0,
    parameter prio_t REQ2_PRIORITY = 2'd0,
    parameter prio_t REQ3_PRIORITY = 2'd0
) (
    input  wire      aclk,
    input  wire      reset,
    input  wire      req_vec_t req,
    output req_vec_t grant
);

    localparam int LVL_NB = 2 ** $bits(prio_t);

    req_vec_t          lvl_req   [LVL_NB];
    req_vec_t          lvl_grant [LVL_NB];
    logic [LVL_NB-1:0] lvl_any;
    logic [LVL_NB-1:0] lvl_active;

    genvar lvl;

    for (lvl = 0; lvl < LVL_NB; lvl++) begin : g_lvl
        // ports that sit at this level.
        localparam req_vec_t LVL_MASK = {
            REQ3_PRIORITY == lvl,
            REQ2_PRIORITY == lvl,
            REQ1_PRIORITY == lvl,
            REQ0_PRIORITY == lvl
        };

        assign lvl_req[lvl] = req & LVL_MASK;
        assign lvl_any[lvl] = |lvl_req[lvl];

        // nothing pending at any higher level.
        assign lvl_active[lvl] = lvl_any[lvl] && ((lvl_any >> (lvl + 1)) == '0);

        if (|LVL_MASK) begin : g_core
            rr_core rr_core_i (
                .aclk  (aclk),
                .reset (reset),
                .en    (lvl_active[lvl]),
                .req   (lvl_req[lvl]),
                .grant (lvl_grant[lvl])
            );
        end else begin : g_none
            assign lvl_grant[lvl] = '0;
        end
    end

    // the highest level with a grant wins.
    always_comb begin
        grant = '0;
        for (int l = 0; l < LVL_NB; l++) begin
            if (|lvl_grant[l]) begin
                grant = lvl_grant[l];
            end
        end
    end

    assert property (@(posedge aclk) disable iff (reset)
        $onehot0(grant));

endmodule

`default_nettype wire

//--- rtl/req_port.sv
`timescale 1ns/10ps
`default_nettype none

module req_port import mem_arb_pkg::*; (
    input  wire   aclk,
    input  wire   reset,
    input  wire   start,
    input  wire   we,
    input  wire   addr_t addr,
    input  wire   data_t wdata,
    input  wire   grant,
    input  wire   data_t mem_rdata,
    output logic  req,
    output logic  busy,
    output logic  done,
    output data_t rdata,
    output logic  cmd_we,
    output addr_t cmd_addr,
    output data_t cmd_wdata
);

    always_ff @(posedge aclk) begin
        if (reset) begin
            req  <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            // response is due one cycle after the grant.
            done <= req && grant;
            if (start) begin
                req  <= 1'b1;
                busy <= 1'b1;
            end else begin
                if (grant) begin
                    req <= 1'b0;
                end
                if (done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // command held until the RAM has taken it.
    always_ff @(posedge aclk) begin
        if (start) begin
            cmd_we    <= we;
            cmd_addr  <= addr;
            cmd_wdata <= wdata;
        end
    end

    // RAM output is valid during the done cycle.
    assign rdata = (done && !cmd_we) ? mem_rdata : '0;

    // one command in flight per port.
    assert property (@(posedge aclk) disable iff (reset)
        start |-> !busy);

endmodule

`default_nettype wire

//--- rtl/shared_ram.sv
`timescale 1ns/10ps
`default_nettype none

module shared_ram import mem_arb_pkg::*; #(
    parameter int RAM_DEPTH = 2 ** ADDR_W
) (
    input  wire   aclk,
    input  wire   en,
    input  wire   we,
    input  wire   addr_t addr,
    input  wire   data_t wdata,
    output data_t rdata
);

    data_t mem [RAM_DEPTH];

    always_ff @(posedge aclk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                // registered read port.
                rdata <= mem[addr];
            end
        end
    end

    // a depth below the address range leaves upper addresses unmapped.
    assert property (@(posedge aclk)
        en |-> (int'(addr) < RAM_DEPTH));

endmodule

`default_nettype wire

//--- rtl/mem_arb_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arb_top import mem_arb_pkg::*; #(
    parameter prio_t REQ0_PRIORITY = 2'd0,
    parameter prio_t REQ1_PRIORITY = 2'd0,
    parameter prio_t REQ2_PRIORITY = 2'd0,
    parameter prio_t REQ3_PRIORITY = 2'd0,
    parameter int    RAM_DEPTH     = 2 ** ADDR_W
) (
    input  wire   aclk,
    input  wire   reset,
    input  wire   start_0,
    input  wire   we_0,
    input  wire   addr_t addr_0,
    input  wire   data_t wdata_0,
    output logic  busy_0,
    output logic  done_0,
    output data_t rdata_0,
    input  wire   start_1,
    input  wire   we_1,
    input  wire   addr_t addr_1,
    input  wire   data_t wdata_1,
    output logic  busy_1,
    output logic  done_1,
    output data_t rdata_1,
    input  wire   start_2,
    input  wire   we_2,
    input  wire   addr_t addr_2,
    input  wire   data_t wdata_2,
    output logic  busy_2,
    output logic  done_2,
    output data_t rdata_2,
    input  wire   start_3,
    input  wire   we_3,
    input  wire   addr_t addr_3,
    input  wire   data_t wdata_3,
    output logic  busy_3,
    output logic  done_3,
    output data_t rdata_3
);

    req_vec_t start_v;
    req_vec_t we_v;
    req_vec_t req_v;
    req_vec_t grant_v;
    req_vec_t busy_v;
    req_vec_t done_v;
    req_vec_t cmd_we_v;
    addr_t    addr_v      [REQ_NB];
    data_t    wdata_v     [REQ_NB];
    data_t    rdata_v     [REQ_NB];
    addr_t    cmd_addr_v  [REQ_NB];
    data_t    cmd_wdata_v [REQ_NB];
    logic     ram_en;
    logic     ram_we;
    addr_t    ram_addr;
    data_t    ram_wdata;
    data_t    ram_rdata;

    assign start_v = {start_3, start_2, start_1, start_0};
    assign we_v    = {we_3, we_2, we_1, we_0};
    assign addr_v  = '{addr_0, addr_1, addr_2, addr_3};
    assign wdata_v = '{wdata_0, wdata_1, wdata_2, wdata_3};

    assign {busy_3, busy_2, busy_1, busy_0} = busy_v;
    assign {done_3, done_2, done_1, done_0} = done_v;
    assign rdata_0 = rdata_v[0];
    assign rdata_1 = rdata_v[1];
    assign rdata_2 = rdata_v[2];
    assign rdata_3 = rdata_v[3];

    genvar n;

    for (n = 0; n < REQ_NB; n++) begin : g_port
        req_port req_port_i (
            .aclk      (aclk),
            .reset     (reset),
            .start     (start_v[n]),
            .we        (we_v[n]),
            .addr      (addr_v[n]),
            .wdata     (wdata_v[n]),
            .grant     (grant_v[n]),
            .mem_rdata (ram_rdata),
            .req       (req_v[n]),
            .busy      (busy_v[n]),
            .done      (done_v[n]),
            .rdata     (rdata_v[n]),
            .cmd_we    (cmd_we_v[n]),
            .cmd_addr  (cmd_addr_v[n]),
            .cmd_wdata (cmd_wdata_v[n])
        );
    end

    prio_rr_arbiter #(
        .REQ0_PRIORITY (REQ0_PRIORITY),
        .REQ1_PRIORITY (REQ1_PRIORITY),
        .REQ2_PRIORITY (REQ2_PRIORITY),
        .REQ3_PRIORITY (REQ3_PRIORITY)
    ) arb_i (
        .aclk  (aclk),
        .reset (reset),
        .req   (req_v),
        .grant (grant_v)
    );

    // and-or select over a one-hot grant.
    always_comb begin
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        for (int i = 0; i < REQ_NB; i++) begin
            ram_we    |= cmd_we_v[i] & grant_v[i];
            ram_addr  |= cmd_addr_v[i] & {ADDR_W{grant_v[i]}};
            ram_wdata |= cmd_wdata_v[i] & {DATA_W{grant_v[i]}};
        end
    end

    assign ram_en = |grant_v;

    shared_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) ram_i (
        .aclk  (aclk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- sim/mem_arb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arb_tb import mem_arb_pkg::*; ();

    // about four times the summed length of all tests.
    localparam int TIMEOUT_CYCLES = 2000;

    logic       aclk = 1'b0;
    logic       reset;
    logic [3:0] start_v;
    logic [3:0] we_v;
    addr_t      addr_a  [REQ_NB];
    data_t      wdata_a [REQ_NB];
    logic [3:0] busy_w;
    logic [3:0] done_w;
    data_t      rdata_w [REQ_NB];

    // reference memory and the command each port carries.
    data_t      model     [2 ** ADDR_W];
    logic       cmd_we    [REQ_NB];
    addr_t      cmd_addr  [REQ_NB];
    data_t      cmd_wdata [REQ_NB];
    int         start_cyc [REQ_NB];
    int         done_cyc  [REQ_NB];
    int         done_q[$];
    logic [3:0] done_seen;
    int         cyc = 0;
    int         errors = 0;

    always #4 aclk = ~aclk;

    mem_arb_top #(
        .REQ0_PRIORITY (2'd0),
        .REQ1_PRIORITY (2'd0),
        .REQ2_PRIORITY (2'd0),
        .REQ3_PRIORITY (2'd1)
    ) mem_arb_top_i (
        .aclk    (aclk),
        .reset   (reset),
        .start_0 (start_v[0]),
        .we_0    (we_v[0]),
        .addr_0  (addr_a[0]),
        .wdata_0 (wdata_a[0]),
        .busy_0  (busy_w[0]),
        .done_0  (done_w[0]),
        .rdata_0 (rdata_w[0]),
        .start_1 (start_v[1]),
        .we_1    (we_v[1]),
        .addr_1  (addr_a[1]),
        .wdata_1 (wdata_a[1]),
        .busy_1  (busy_w[1]),
        .done_1  (done_w[1]),
        .rdata_1 (rdata_w[1]),
        .start_2 (start_v[2]),
        .we_2    (we_v[2]),
        .addr_2  (addr_a[2]),
        .wdata_2 (wdata_a[2]),
        .busy_2  (busy_w[2]),
        .done_2  (done_w[2]),
        .rdata_2 (rdata_w[2]),
        .start_3 (start_v[3]),
        .we_3    (we_v[3]),
        .addr_3  (addr_a[3]),
        .wdata_3 (wdata_a[3]),
        .busy_3  (busy_w[3]),
        .done_3  (done_w[3]),
        .rdata_3 (rdata_w[3])
    );

    always @(posedge aclk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_port(string name, int got, int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // done order is RAM access order, so the model follows it.
    always @(negedge aclk) begin
        if (!reset) begin
            for (int p = 0; p < REQ_NB; p++) begin
                if (done_w[p]) begin
                    done_q.push_back(p);
                    done_seen[p] = 1'b1;
                    done_cyc[p] = cyc;
                    if (cmd_we[p]) begin
                        model[cmd_addr[p]] = cmd_wdata[p];
                    end else begin
                        check_data($sformatf("rdata_%0d", p), rdata_w[p], model[cmd_addr[p]]);
                    end
                end
            end
        end
    end

    task automatic step();
        @(posedge aclk);
        #1;
        start_v = '0;
    endtask

    task automatic issue(int p, logic we, addr_t a, data_t d);
        start_v[p] = 1'b1;
        we_v[p] = we;
        addr_a[p] = a;
        wdata_a[p] = d;
        cmd_we[p] = we;
        cmd_addr[p] = a;
        cmd_wdata[p] = d;
        start_cyc[p] = cyc;
        done_cyc[p] = -1;
    endtask

    task automatic wait_idle();
        do begin
            step();
        end while (busy_w != '0);
    endtask

    task automatic apply_reset();
        @(posedge aclk);
        #1;
        start_v = '0;
        reset = 1'b1;
        repeat (3) @(posedge aclk);
        #1;
        reset = 1'b0;
        done_q.delete();
        done_seen = '0;
    endtask

    task automatic check_done_count(int n);
        if (done_q.size() != n) begin
            $display("expected %0d completed transactions, saw %0d", n, done_q.size());
            errors++;
        end
    endtask

    task automatic single_access(int p, logic we, addr_t a, data_t d);
        step();
        issue(p, we, a, d);
        wait_idle();
        if (done_cyc[p] - start_cyc[p] != 2) begin
            $display("port %0d: done came %0d cycles after start instead of 2",
                     p, done_cyc[p] - start_cyc[p]);
            errors++;
        end
    endtask

    task automatic test_single_port();
        for (int p = 0; p < REQ_NB; p++) begin
            single_access(p, 1'b1, addr_t'(8'h10 + p), $urandom());
            single_access(p, 1'b0, addr_t'(8'h10 + p), '0);
        end
    endtask

    task automatic test_round_robin();
        apply_reset();
        step();
        for (int p = 0; p < 3; p++) begin
            issue(p, 1'b0, addr_t'(8'h10 + p), '0);
        end
        wait_idle();
        check_done_count(3);
        for (int i = 0; i < done_q.size() && i < 3; i++) begin
            check_port("done order", done_q[i], i);
        end
    endtask

    task automatic test_priority();
        apply_reset();
        step();
        issue(0, 1'b0, 8'h10, '0);
        issue(3, 1'b0, 8'h13, '0);
        wait_idle();
        check_done_count(2);
        for (int i = 0; i < done_q.size() && i < 2; i++) begin
            check_port("done order", done_q[i], (i == 0) ? 3 : 0);
        end
    endtask

    task automatic test_rotation();
        int issued;
        apply_reset();
        step();
        for (int p = 0; p < 3; p++) begin
            issue(p, 1'b0, addr_t'(8'h10 + p), '0);
        end
        issued = 3;
        // restart each port in the cycle after its done.
        while (done_q.size() < 9) begin
            step();
            for (int p = 0; p < 3; p++) begin
                if (done_seen[p] && issued < 9) begin
                    issue(p, 1'b0, addr_t'(8'h10 + p), '0);
                    issued++;
                end
            end
            done_seen = '0;
        end
        wait_idle();
        check_done_count(9);
        for (int i = 0; i < done_q.size() && i < 9; i++) begin
            check_port("done order", done_q[i], i % 3);
        end
    endtask

    task automatic run_random(int n_cycles);
        for (int c = 0; c < n_cycles; c++) begin
            step();
            for (int p = 0; p < REQ_NB; p++) begin
                if (!busy_w[p] && ($urandom_range(3) == 0)) begin
                    issue(p, 1'($urandom_range(1)), addr_t'(8'h40 + $urandom_range(15)),
                          $urandom());
                end
            end
        end
    endtask

    task automatic test_random_traffic();
        // fill the window first so every read has a known value.
        for (int a = 0; a < 16; a++) begin
            step();
            issue(a % REQ_NB, 1'b1, addr_t'(8'h40 + a), $urandom());
            wait_idle();
        end
        run_random(300);
        wait_idle();
    endtask

    task automatic test_reset_mid_traffic();
        run_random(20);
        apply_reset();
        if (busy_w != '0 || done_w != '0) begin
            $display("busy or done still high on some port right after reset");
            errors++;
        end
        step();
        issue(0, 1'b1, 8'h20, $urandom());
        issue(1, 1'b1, 8'h21, $urandom());
        wait_idle();
        check_done_count(2);
        for (int i = 0; i < done_q.size() && i < 2; i++) begin
            check_port("done order", done_q[i], i);
        end
    endtask

    initial begin
        void'($urandom(32'h37e1));
        reset = 1'b1;
        start_v = '0;
        we_v = '0;
        done_seen = '0;
        for (int p = 0; p < REQ_NB; p++) begin
            addr_a[p] = '0;
            wdata_a[p] = '0;
            cmd_we[p] = 1'b0;
            cmd_addr[p] = '0;
            cmd_wdata[p] = '0;
        end
        repeat (3) @(posedge aclk);
        #1;
        reset = 1'b0;
        test_single_port();
        test_round_robin();
        test_priority();
        test_rotation();
        test_random_traffic();
        test_reset_mid_traffic();
        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/mem_arb_pkg.sv
rtl/rr_core.sv
rtl/prio_rr_arbiter.sv
rtl/req_port.sv
rtl/shared_ram.sv
rtl/mem_arb_top.sv
sim/mem_arb_tb.sv

//--- Makefile
TOP := mem_arb_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
